/* design/smc_lite_pkg.sv */
// widths, wait-state count, vector typedefs and bus phase enum for the lite SMC
`default_nettype none

package smc_lite_pkg;

  // ------------------------------
  // widths
  // ------------------------------

  // word address, host and memory side
  localparam int SMC_ADDR_W = 16;

  // data bus width
  localparam int SMC_DATA_W = 32;

  // one byte lane per 8 data bits
  localparam int SMC_LANES = SMC_DATA_W / 8;

  // ------------------------------
  // timing
  // ------------------------------

  // extra strobe cycles beyond the first
  localparam int SMC_WAIT_STATES = 2;

  // wait counter width, at least one bit
  localparam int SMC_WAIT_W = (SMC_WAIT_STATES > 0) ? $clog2(SMC_WAIT_STATES + 1) : 1;

  // ------------------------------
  // types
  // ------------------------------

  typedef logic [SMC_ADDR_W-1:0] smc_addr_t;
  typedef logic [SMC_DATA_W-1:0] smc_data_t;
  typedef logic [SMC_LANES-1:0]  smc_lane_t;

  // external bus phases
  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    STROBE,
    HOLD
  } smc_state_t;

endpackage

`default_nettype wire

/* design/smc_cycle_fsm.sv */
// bus cycle sequencer with request acceptance, setup/strobe/hold phases and raw strobes
`timescale 1ns/1ns
`default_nettype none

module smc_cycle_fsm
  import smc_lite_pkg::*;
(
  input  wire logic       hclk,
  input  wire logic       rst_n,
  // host request channel
  input  wire logic       req_valid,
  input  wire logic       req_write,
  input  wire smc_addr_t  req_addr,
  input  wire smc_data_t  req_wdata,
  input  wire smc_lane_t  req_be,
  output logic            req_ready,
  // response still held by the capture block
  input  wire logic       rsp_pending,
  // memory pins
  output smc_addr_t       smc_addr,
  output smc_data_t       smc_data_out,
  output logic            smc_data_oe,
  output logic            smc_n_cs,
  output logic            smc_n_oe,
  // raw write strobes, gated downstream
  output logic            r_full,
  output smc_lane_t       n_r_we,
  output logic            n_r_wr,
  // read data capture pulse
  output logic            capture_en
);

  smc_state_t              state;
  smc_state_t              state_nxt;
  logic [SMC_WAIT_W-1:0]   wait_cnt;
  logic                    wr_q;
  smc_addr_t               addr_q;
  smc_data_t               wdata_q;
  smc_lane_t               be_q;
  logic                    accept;
  logic                    active;
  logic                    last_strobe;

  // ------------------------------
  // handshake and phase decode
  // ------------------------------

  // one cycle in flight and none while a read response waits
  assign req_ready   = (state == IDLE) && !rsp_pending;
  assign accept      = req_valid && req_ready;
  assign active      = (state != IDLE);
  assign last_strobe = (state == STROBE) && (wait_cnt == '0);

  // next phase
  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
        if (accept)
          state_nxt = SETUP;
      SETUP:
        state_nxt = STROBE;
      STROBE:
        if (wait_cnt == '0)
          state_nxt = HOLD;
      HOLD:
        state_nxt = IDLE;
      default:
        state_nxt = IDLE;
    endcase
  end

  // phase register, wait counter and cycle direction
  always_ff @(posedge hclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      wait_cnt <= '0;
      wr_q     <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      // load on strobe entry and count down inside strobe
      if (state == SETUP)
        wait_cnt <= SMC_WAIT_W'(SMC_WAIT_STATES);
      else if ((state == STROBE) && (wait_cnt != '0))
        wait_cnt <= wait_cnt - 1'b1;
      if (accept)
        wr_q <= req_write;
    end
  end

  // request payload held for the whole bus cycle
  always_ff @(posedge hclk)
  begin
    if (accept)
    begin
      addr_q  <= req_addr;
      wdata_q <= req_wdata;
      be_q    <= req_be;
    end
  end

  // ------------------------------
  // memory side drive
  // ------------------------------

  assign smc_addr     = addr_q;
  assign smc_data_out = wdata_q;
  // drive the data bus for the whole write cycle
  assign smc_data_oe  = active && wr_q;
  assign smc_n_cs     = !active;
  // output enable only while strobing a read
  assign smc_n_oe     = !((state == STROBE) && !wr_q);

  // raw enables span setup to hold and r_full trims them to the strobe
  assign n_r_we = (active && wr_q) ? ~be_q : '1;
  assign n_r_wr = !(active && wr_q);
  assign r_full = (state == STROBE) && wr_q;

  // sample read data at the edge ending the last strobe cycle
  assign capture_en = last_strobe && !wr_q;

  // ------------------------------
  // checks
  // ------------------------------

  // bus never read and written in the same cycle
  a_no_oe_during_wr: assert property (
    @(posedge hclk) disable iff (!rst_n)
    !(!smc_n_oe && !n_r_wr)
  );

endmodule

`default_nettype wire

/* design/smc_wr_enable_lite.sv */
// write enable gating of the raw lane enables and write strobe
`timescale 1ns/1ns
`default_nettype none

module smc_wr_enable_lite
  import smc_lite_pkg::*;
(
  input  wire logic       r_full,
  input  wire smc_lane_t  n_r_we,
  input  wire logic       n_r_wr,
  output smc_lane_t       smc_n_we,
  output logic            smc_n_wr
);

  // ------------------------------
  // gate strobes with full cycle
  // ------------------------------

  always_comb
  begin
    // forced high outside the strobe phase
    smc_n_we = n_r_we | {SMC_LANES{~r_full}};
    smc_n_wr = n_r_wr | ~r_full;

    // a lane only writes under the global strobe
    if (!(&smc_n_we))
      assert (!smc_n_wr);
  end

endmodule

`default_nettype wire

/* design/smc_rd_capture.sv */
// read data capture register and host response channel
`timescale 1ns/1ns
`default_nettype none

module smc_rd_capture
  import smc_lite_pkg::*;
(
  input  wire logic       hclk,
  input  wire logic       rst_n,
  // from the sequencer, last read strobe cycle
  input  wire logic       capture_en,
  input  wire smc_data_t  smc_data_in,
  // host response channel
  input  wire logic       rsp_ready,
  output logic            rsp_valid,
  output smc_data_t       rsp_rdata,
  // back to the sequencer
  output logic            rsp_pending
);

  // ------------------------------
  // response valid
  // ------------------------------

  always_ff @(posedge hclk or negedge rst_n)
  begin
    if (!rst_n)
      rsp_valid <= 1'b0;
    else if (capture_en)
      rsp_valid <= 1'b1;
    else if (rsp_ready)
      rsp_valid <= 1'b0;
  end

  // data register, loads only on capture
  always_ff @(posedge hclk)
  begin
    if (capture_en)
      rsp_rdata <= smc_data_in;
  end

  // blocks new bus cycles until the host takes the data
  assign rsp_pending = rsp_valid;

  // ------------------------------
  // checks
  // ------------------------------

  // response held stable under back-pressure
  a_rsp_stable: assert property (
    @(posedge hclk) disable iff (!rst_n)
    (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_rdata))
  );

endmodule

`default_nettype wire

/* design/smc_lite_top.sv */
// top level of the lite SMC: sequencer, write enable gating and read capture
`timescale 1ns/1ns
`default_nettype none

module smc_lite_top
  import smc_lite_pkg::*;
(
  input  wire logic       hclk,
  input  wire logic       rst_n,
  // host request channel
  input  wire logic       req_valid,
  input  wire logic       req_write,
  input  wire smc_addr_t  req_addr,
  input  wire smc_data_t  req_wdata,
  input  wire smc_lane_t  req_be,
  output logic            req_ready,
  // host response channel, reads only
  output logic            rsp_valid,
  output smc_data_t       rsp_rdata,
  input  wire logic       rsp_ready,
  // memory pins
  output smc_addr_t       smc_addr,
  output smc_data_t       smc_data_out,
  output logic            smc_data_oe,
  input  wire smc_data_t  smc_data_in,
  output logic            smc_n_cs,
  output logic            smc_n_oe,
  output smc_lane_t       smc_n_we,
  output logic            smc_n_wr
);

  // ------------------------------
  // internal nets
  // ------------------------------

  logic       r_full;
  smc_lane_t  n_r_we;
  logic       n_r_wr;
  logic       capture_en;
  logic       rsp_pending;

  // phase sequencing and pin drive
  smc_cycle_fsm smc_cycle_fsm_i (
    .hclk         (hclk),
    .rst_n        (rst_n),
    .req_valid    (req_valid),
    .req_write    (req_write),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata),
    .req_be       (req_be),
    .req_ready    (req_ready),
    .rsp_pending  (rsp_pending),
    .smc_addr     (smc_addr),
    .smc_data_out (smc_data_out),
    .smc_data_oe  (smc_data_oe),
    .smc_n_cs     (smc_n_cs),
    .smc_n_oe     (smc_n_oe),
    .r_full       (r_full),
    .n_r_we       (n_r_we),
    .n_r_wr       (n_r_wr),
    .capture_en   (capture_en)
  );

  // write pulses trimmed to the strobe phase
  smc_wr_enable_lite smc_wr_enable_lite_i (
    .r_full   (r_full),
    .n_r_we   (n_r_we),
    .n_r_wr   (n_r_wr),
    .smc_n_we (smc_n_we),
    .smc_n_wr (smc_n_wr)
  );

  // read data to the response channel
  smc_rd_capture smc_rd_capture_i (
    .hclk        (hclk),
    .rst_n       (rst_n),
    .capture_en  (capture_en),
    .smc_data_in (smc_data_in),
    .rsp_ready   (rsp_ready),
    .rsp_valid   (rsp_valid),
    .rsp_rdata   (rsp_rdata),
    .rsp_pending (rsp_pending)
  );

endmodule

`default_nettype wire

/* verification/sram_model.sv */
// behavioral asynchronous byte-lane SRAM, 256 words, hung on the SMC memory pins
`timescale 1ns/1ns
`default_nettype none

module sram_model
  import smc_lite_pkg::*;
(
  input  wire smc_addr_t  smc_addr,
  input  wire smc_data_t  smc_data_out,
  input  wire logic       smc_data_oe,
  input  wire logic       smc_n_cs,
  input  wire logic       smc_n_oe,
  input  wire smc_lane_t  smc_n_we,
  output smc_data_t       smc_data_in
);

  smc_data_t  bus_data;
  smc_data_t  rd_word;
  logic       rd_drive;

  // ------------------------------
  // data bus resolution
  // ------------------------------

  // memory drives only while selected with output enable low
  assign rd_drive    = !smc_n_cs && !smc_n_oe;
  // controller side wins when it drives, idle bus reads as zero
  assign bus_data    = smc_data_oe ? smc_data_out : (rd_drive ? rd_word : '0);
  assign smc_data_in = bus_data;

  // ------------------------------
  // byte lane arrays
  // ------------------------------

  for (genvar g = 0; g < SMC_LANES; g++)
  begin : lane_g
    logic [7:0] lane_mem [0:255];

    // power-up contents, a function of word index and lane
    initial
    begin
      for (int i = 0; i < 256; i++)
        lane_mem[i] = 8'(i) ^ (8'h11 * 8'(g + 1));
    end

    // lane written on the trailing edge of its enable
    always @(posedge smc_n_we[g])
    begin
      if (!smc_n_cs)
        lane_mem[smc_addr[7:0]] = bus_data[8*g +: 8];
    end

    // asynchronous read path
    assign rd_word[8*g +: 8] = lane_mem[smc_addr[7:0]];
  end

endmodule

`default_nettype wire

/* verification/tb_smc_lite.sv */
// lite SMC testbench with clock, reset, directed tests, compare tasks, mirror and timeout
`timescale 1ns/1ns
`default_nettype none

module tb_smc_lite
  import smc_lite_pkg::*;
();

  localparam int          CLK_HALF       = 20;
  localparam int          RESET_CYCLES   = 10;
  localparam int unsigned RAND_SEED      = 32'h60faecc6;
  // about 60 ops of at most 15 cycles doubled plus reset and stall slack
  localparam int          MAX_OPS        = 60;
  localparam int          OP_CYCLES_MAX  = 15;
  localparam int          TIMEOUT_CYCLES = 2 * MAX_OPS * OP_CYCLES_MAX + 200;

  logic       hclk;
  logic       rst_n;
  logic       req_valid;
  logic       req_write;
  smc_addr_t  req_addr;
  smc_data_t  req_wdata;
  smc_lane_t  req_be;
  logic       req_ready;
  logic       rsp_valid;
  smc_data_t  rsp_rdata;
  logic       rsp_ready;
  smc_addr_t  smc_addr;
  smc_data_t  smc_data_out;
  logic       smc_data_oe;
  smc_data_t  smc_data_in;
  logic       smc_n_cs;
  logic       smc_n_oe;
  smc_lane_t  smc_n_we;
  logic       smc_n_wr;

  // expected memory contents aliased on the low 8 address bits
  smc_data_t  mirror [0:256-1];
  int         cycle_cnt = 0;

  smc_lite_top smc_lite_top_i (
    .hclk (hclk), .rst_n (rst_n),
    .req_valid (req_valid), .req_write (req_write), .req_addr (req_addr),
    .req_wdata (req_wdata), .req_be (req_be), .req_ready (req_ready),
    .rsp_valid (rsp_valid), .rsp_rdata (rsp_rdata), .rsp_ready (rsp_ready),
    .smc_addr (smc_addr), .smc_data_out (smc_data_out), .smc_data_oe (smc_data_oe),
    .smc_data_in (smc_data_in), .smc_n_cs (smc_n_cs), .smc_n_oe (smc_n_oe),
    .smc_n_we (smc_n_we), .smc_n_wr (smc_n_wr)
  );

  sram_model sram_model_i (
    .smc_addr (smc_addr), .smc_data_out (smc_data_out), .smc_data_oe (smc_data_oe),
    .smc_n_cs (smc_n_cs), .smc_n_oe (smc_n_oe), .smc_n_we (smc_n_we),
    .smc_data_in (smc_data_in)
  );

  initial
  begin
    hclk = 1'b0;
    forever #CLK_HALF hclk = ~hclk;
  end

  // run limit
  always @(posedge hclk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout: no completion after %0d clock cycles", cycle_cnt);
      $display("TEST FAIL");
      $fatal(1, "run aborted on timeout");
    end
  end

  // ------------------------------
  // compare tasks
  // ------------------------------

  task automatic check_data(input string name, input smc_data_t exp, input smc_data_t act);
    if (act !== exp)
    begin
      $display("MISMATCH at %0t ns: %s expected %h actual %h", $time, name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic check_lane(input string name, input smc_lane_t exp, input smc_lane_t act);
    if (act !== exp)
    begin
      $display("MISMATCH at %0t ns: %s expected %b actual %b", $time, name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("MISMATCH at %0t ns: %s expected %b actual %b", $time, name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp)
    begin
      $display("MISMATCH at %0t ns: %s expected %0d actual %0d", $time, name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  // ------------------------------
  // mirror and bus helpers
  // ------------------------------

  // sram power-up word with each lane the index xor a lane constant
  function automatic smc_data_t fill_word(input logic [7:0] idx);
    return {idx ^ 8'h44, idx ^ 8'h33, idx ^ 8'h22, idx ^ 8'h11};
  endfunction

  task automatic mirror_merge(input smc_addr_t addr, input smc_data_t data,
                              input smc_lane_t be);
    for (int l = 0; l < SMC_LANES; l++)
    begin
      if (be[l])
        mirror[addr[7:0]][8*l +: 8] = data[8*l +: 8];
    end
  endtask

  // caller sits on a rising edge
  task automatic drive_req(input logic write, input smc_addr_t addr,
                           input smc_data_t wdata, input smc_lane_t be);
    req_valid <= 1'b1;
    req_write <= write;
    req_addr  <= addr;
    req_wdata <= wdata;
    req_be    <= be;
  endtask

  // returns on the acceptance edge
  task automatic wait_accept();
    do
    begin
      @(negedge hclk);
    end
    while (!req_ready);
    @(posedge hclk);
  endtask

  // negedges counted from the acceptance edge until rsp_valid shows
  task automatic wait_rsp(output int cycles);
    cycles = 0;
    do
    begin
      @(negedge hclk);
      cycles++;
    end
    while (!rsp_valid);
  endtask

  task automatic issue_req(input logic write, input smc_addr_t addr,
                           input smc_data_t wdata, input smc_lane_t be);
    @(posedge hclk);
    drive_req(write, addr, wdata, be);
    wait_accept();
    req_valid <= 1'b0;
  endtask

  task automatic do_write(input smc_addr_t addr, input smc_data_t data, input smc_lane_t be);
    issue_req(1'b1, addr, data, be);
    mirror_merge(addr, data, be);
  endtask

  // read with rsp_ready high and check latency and data
  task automatic read_check(input smc_addr_t addr);
    int cycles;
    issue_req(1'b0, addr, '0, '0);
    wait_rsp(cycles);
    check_count("rsp_valid latency", SMC_WAIT_STATES + 2, cycles - 1);
    check_data("rsp_rdata", mirror[addr[7:0]], rsp_rdata);
    @(posedge hclk);
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------

  task automatic reset_values();
    @(negedge hclk);
    check_bit("smc_n_cs", 1'b1, smc_n_cs);
    check_bit("smc_n_oe", 1'b1, smc_n_oe);
    check_bit("smc_n_wr", 1'b1, smc_n_wr);
    check_lane("smc_n_we", '1, smc_n_we);
    check_bit("smc_data_oe", 1'b0, smc_data_oe);
    check_bit("rsp_valid", 1'b0, rsp_valid);
    check_bit("req_ready", 1'b1, req_ready);
  endtask

  task automatic full_word_rw();
    smc_addr_t addrs [4];
    addrs = '{16'h0010, 16'h0011, 16'h00a5, 16'hff03};
    for (int i = 0; i < 4; i++)
      do_write(addrs[i], $urandom, 4'b1111);
    for (int i = 0; i < 4; i++)
      read_check(addrs[i]);
  endtask

  task automatic byte_lane_merge();
    smc_lane_t patterns [5];
    patterns = '{4'b0001, 4'b0110, 4'b1000, 4'b1010, 4'b0000};
    do_write(16'h0123, 32'h1234_5678, 4'b1111);
    read_check(16'h0123);
    for (int p = 0; p < 5; p++)
    begin
      do_write(16'h0123, $urandom, patterns[p]);
      read_check(16'h0123);
    end
  endtask

  task automatic write_strobe_shape(input smc_lane_t be);
    smc_addr_t addr;
    smc_data_t data;
    int        cycles;
    int        wr_low;
    addr   = {8'h03, 4'h0, be};
    data   = $urandom;
    cycles = 0;
    wr_low = 0;
    do_write(addr, data, be);
    // lane enables only inside the strobe window
    do
    begin
      @(negedge hclk);
      cycles++;
      if (!smc_n_wr)
      begin
        wr_low++;
        check_lane("smc_n_we", ~be, smc_n_we);
      end
      else
        check_lane("smc_n_we", '1, smc_n_we);
    end
    while (!req_ready);
    check_count("smc_n_wr low cycles", SMC_WAIT_STATES + 1, wr_low);
    check_count("req_ready return", SMC_WAIT_STATES + 3, cycles - 1);
    read_check(addr);
  endtask

  task automatic response_backpressure();
    int unsigned stall;
    int          cycles;
    stall = $urandom_range(10, 1);
    @(posedge hclk);
    rsp_ready <= 1'b0;
    issue_req(1'b0, 16'h0042, '0, '0);
    // second request waits behind the held response
    @(posedge hclk);
    drive_req(1'b0, 16'h0077, '0, '0);
    wait_rsp(cycles);
    check_data("rsp_rdata", mirror[8'h42], rsp_rdata);
    repeat (stall)
    begin
      @(negedge hclk);
      check_bit("req_ready", 1'b0, req_ready);
      check_bit("rsp_valid", 1'b1, rsp_valid);
      check_data("rsp_rdata", mirror[8'h42], rsp_rdata);
    end
    @(posedge hclk);
    rsp_ready <= 1'b1;
    wait_accept();
    req_valid <= 1'b0;
    wait_rsp(cycles);
    check_data("rsp_rdata", mirror[8'h77], rsp_rdata);
    @(posedge hclk);
  endtask

  task automatic random_mix();
    smc_addr_t addr;
    smc_lane_t be;
    for (int n = 0; n < 40; n++)
    begin
      // 16 words with varying upper bits so aliased words are hit too
      addr = {8'($urandom), 4'h0, 4'($urandom)};
      be   = smc_lane_t'($urandom);
      if ($urandom_range(1, 0) == 1)
        do_write(addr, $urandom, be);
      else
        read_check(addr);
    end
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial
  begin
    void'($urandom(RAND_SEED));
    for (int i = 0; i < 256; i++)
      mirror[i] = fill_word(8'(i));
    rst_n     <= 1'b0;
    req_valid <= 1'b0;
    req_write <= 1'b0;
    req_addr  <= '0;
    req_wdata <= '0;
    req_be    <= '0;
    rsp_ready <= 1'b1;
    repeat (RESET_CYCLES) @(posedge hclk);
    rst_n <= 1'b1;

    reset_values();
    full_word_rw();
    byte_lane_merge();
    write_strobe_shape(4'b1111);
    write_strobe_shape(4'b0101);
    write_strobe_shape(4'b1000);
    response_backpressure();
    random_mix();

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
design/smc_lite_pkg.sv
design/smc_cycle_fsm.sv
design/smc_wr_enable_lite.sv
design/smc_rd_capture.sv
design/smc_lite_top.sv
verification/sram_model.sv
verification/tb_smc_lite.sv

/* run_sim.sh */
#!/bin/sh
# build and run the lite SMC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_smc_lite -Mdir obj_dir -f flist.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_smc_lite 2>&1)
status=$?
printf '%s\n' "$sim_out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'TEST PASS'; then
  exit 0
fi
echo "pass message missing from simulation output"
exit 1
